// ==== compile.f ====
+incdir+logic
logic/melbank_pkg.sv
logic/mel_weight_rom.sv
logic/tri_accum.sv
logic/energy_log.sv
logic/bank_store.sv
logic/mel_filterbank.sv
sim/mel_filterbank_assert.sv
sim/mel_filterbank_tb.sv

// ==== logic/bank_store.sv ====
`include "melbank_cfg.svh"

module bank_store (
    input  logic              clk,
    input  logic              reset,
    input  logic              push,
    input  logic              push_last,
    input  melbank_pkg::log_t code,
    output melbank_pkg::log_t bands [`MEL_NUM_BANKS],
    output logic              frame_done
);

    localparam int TOP = `MEL_NUM_BANKS - 1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `MEL_NUM_BANKS; i++) begin
                bands[i] <= '0;
            end
        end else if (push) begin
            for (int i = 0; i < TOP; i++) begin
                bands[i] <= bands[i+1];                // Older filters move toward index 0
            end
            bands[TOP] <= code;                        // Newest filter enters on top
        end
    end

    // Bank is complete once the last filter of the frame is in
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            frame_done <= 1'b0;
        end else begin
            frame_done <= push & push_last;
        end
    end

endmodule

// ==== logic/energy_log.sv ====
module energy_log (
    input  melbank_pkg::acc_t energy,
    output melbank_pkg::log_t code
);

    localparam int ACC_W  = $bits(melbank_pkg::acc_t);
    localparam int LEAD_W = $clog2(ACC_W);
    localparam int HALF_W = $bits(melbank_pkg::log_t) / 2;

    logic [LEAD_W-1:0] lead;                           // Index of the leading one
    melbank_pkg::acc_t norm;                           // Leading one moved to the MSB
    logic [4:0]        mant;
    logic [7:0]        frac;

    // Priority encoder, highest set bit wins
    always_comb begin
        lead = '0;
        for (int i = 0; i < ACC_W; i++) begin
            if (energy[i]) begin
                lead = LEAD_W'(i);
            end
        end
    end

    // Left shift zero-fills the mantissa when fewer than five bits sit below the lead
    assign norm = energy << ((ACC_W - 1) - int'(lead));
    assign mant = norm[ACC_W-2 -: 5];
    assign frac = melbank_pkg::log_frac(mant);

    always_comb begin
        if (energy == '0) begin
            code = '0;                                 // log of zero pinned to code 0
        end else begin
            code = {HALF_W'(lead), HALF_W'(frac)};     // Q8.8 integer and fraction
        end
    end

endmodule

// ==== logic/mel_filterbank.sv ====
`include "melbank_cfg.svh"

module mel_filterbank (
    input  logic               clk,
    input  logic               reset,
    input  melbank_pkg::spec_t spec_in,
    output melbank_pkg::log_t  bands [`MEL_NUM_BANKS],
    output logic               frame_done
);

    melbank_pkg::weight_t weight;
    logic                 peak;
    logic                 frame_first;
    melbank_pkg::acc_t    energy;                      // Finished filter sum
    logic                 push;
    logic                 push_last;
    melbank_pkg::log_t    code;

    mel_weight_rom u_weight_rom (
        .clk         (clk),
        .reset       (reset),
        .weight      (weight),
        .peak        (peak),
        .frame_first (frame_first)
    );

    tri_accum u_tri_accum (
        .clk         (clk),
        .reset       (reset),
        .spec_in     (spec_in),
        .weight      (weight),
        .peak        (peak),
        .frame_first (frame_first),
        .energy      (energy),
        .push        (push),
        .push_last   (push_last)
    );

    energy_log u_energy_log (
        .energy (energy),
        .code   (code)
    );

    bank_store u_bank_store (
        .clk        (clk),
        .reset      (reset),
        .push       (push),
        .push_last  (push_last),
        .code       (code),
        .bands      (bands),
        .frame_done (frame_done)
    );

endmodule

// ==== logic/mel_weight_rom.sv ====
`include "melbank_cfg.svh"

module mel_weight_rom (
    input  logic                 clk,
    input  logic                 reset,
    output melbank_pkg::weight_t weight,
    output logic                 peak,
    output logic                 frame_first
);

    localparam int CNT_W = $clog2(`MEL_NUM_BINS);
    localparam melbank_pkg::weight_t WEIGHT_ONE = 16'd32768; // 1.0 in Q1.15

    logic [CNT_W-1:0]     bin_cnt;                    // Bin being sampled this cycle
    melbank_pkg::weight_t weight_rom [`MEL_NUM_BINS];

    if (`MEL_NUM_BINS != `MEL_NUM_BANKS * `MEL_SPACING) begin : g_geometry_check
        $error("MEL_NUM_BINS must equal MEL_NUM_BANKS * MEL_SPACING");
    end

    // Linear rising ramp between peaks, unity at each peak
    for (genvar b = 0; b < `MEL_NUM_BINS; b++) begin : g_rom
        localparam int K = b % `MEL_SPACING;
        assign weight_rom[b] = (K == 0) ? WEIGHT_ONE
                                        : melbank_pkg::weight_t'((K * 32768) / `MEL_SPACING);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bin_cnt <= '0;
        end else if (bin_cnt == CNT_W'(`MEL_NUM_BINS - 1)) begin
            bin_cnt <= '0;                            // Frames follow back to back
        end else begin
            bin_cnt <= bin_cnt + 1'b1;
        end
    end

    assign weight      = weight_rom[bin_cnt];
    assign peak        = (weight == WEIGHT_ONE);      // Only the peak bins carry unity
    assign frame_first = (bin_cnt == '0);

endmodule

// ==== logic/melbank_cfg.svh ====
`ifndef MELBANK_CFG_SVH
`define MELBANK_CFG_SVH

// Frame geometry
`define MEL_NUM_BINS  240   // Power bins per frame
`define MEL_NUM_BANKS 40    // Triangular filters per frame
`define MEL_SPACING   6     // Bins between adjacent filter peaks

// Word widths
`define MEL_SPEC_W 24       // One power bin
`define MEL_ACC_W  32       // Products and accumulators
`define MEL_LOG_W  16       // Q8.8 log2 code

`endif

// ==== logic/melbank_pkg.sv ====
`include "melbank_cfg.svh"

package melbank_pkg;

    typedef logic [`MEL_SPEC_W-1:0] spec_t;  // Unsigned power bin
    typedef logic [15:0]            weight_t; // Q1.15, 32768 is unity
    typedef logic [`MEL_ACC_W-1:0]  acc_t;    // Product and sum word
    typedef logic [`MEL_LOG_W-1:0]  log_t;    // Q8.8 log2 code

    // round(256 * log2(1 + i/32)) for i = 0..31
    localparam logic [7:0] LOG_FRAC_LUT [32] = '{
        8'd0,   8'd11,  8'd22,  8'd33,  8'd44,  8'd54,  8'd63,  8'd73,
        8'd82,  8'd92,  8'd100, 8'd109, 8'd118, 8'd126, 8'd134, 8'd142,
        8'd150, 8'd157, 8'd165, 8'd172, 8'd179, 8'd186, 8'd193, 8'd200,
        8'd207, 8'd213, 8'd220, 8'd226, 8'd232, 8'd238, 8'd244, 8'd250
    };

    // Fractional part of the log for a 5-bit mantissa below the leading one
    function automatic logic [7:0] log_frac(input logic [4:0] idx);
        return LOG_FRAC_LUT[idx];
    endfunction

endpackage

// ==== logic/tri_accum.sv ====
module tri_accum (
    input  logic                 clk,
    input  logic                 reset,
    input  melbank_pkg::spec_t   spec_in,
    input  melbank_pkg::weight_t weight,
    input  logic                 peak,
    input  logic                 frame_first,
    output melbank_pkg::acc_t    energy,
    output logic                 push,
    output logic                 push_last
);

    localparam int SPEC_W = $bits(melbank_pkg::spec_t);
    localparam int PROD_W = SPEC_W + $bits(melbank_pkg::weight_t);

    // Multiplier input registers
    melbank_pkg::spec_t   spec_q;
    melbank_pkg::weight_t weight_q;
    logic                 peak_q;
    logic                 first_q;

    // First product stage
    logic [PROD_W-1:0]    full_prod;
    melbank_pkg::acc_t    prod_a;
    melbank_pkg::acc_t    comp_a;
    melbank_pkg::spec_t   spec_d;                      // Input aligned with prod_a
    logic                 peak_d1;
    logic                 first_d1;

    // Second product stage
    melbank_pkg::acc_t    prod_b;
    melbank_pkg::acc_t    comp_b;
    logic                 peak_d2;
    logic                 first_d2;

    // Shared rising and falling sums
    melbank_pkg::acc_t    asc;
    melbank_pkg::acc_t    desc;

    assign full_prod = PROD_W'(spec_q) * PROD_W'(weight_q);
    assign comp_a    = melbank_pkg::acc_t'(spec_d) - prod_a; // Falling side share

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            spec_q   <= '0;
            weight_q <= '0;
            peak_q   <= 1'b0;
            first_q  <= 1'b0;
            prod_a   <= '0;
            spec_d   <= '0;
            peak_d1  <= 1'b0;
            first_d1 <= 1'b0;
            prod_b   <= '0;
            comp_b   <= '0;
            peak_d2  <= 1'b0;
            first_d2 <= 1'b0;
            asc      <= '0;
            desc     <= '0;
        end else begin
            spec_q   <= spec_in;
            weight_q <= weight;
            peak_q   <= peak;
            first_q  <= frame_first;

            prod_a   <= melbank_pkg::acc_t'(full_prod[PROD_W-1:15]); // Drop Q1.15 scale
            spec_d   <= spec_q;
            peak_d1  <= peak_q;
            first_d1 <= first_q;

            prod_b   <= prod_a;
            comp_b   <= comp_a;
            peak_d2  <= peak_d1;
            first_d2 <= first_d1;

            if (peak_d2) begin
                asc  <= '0;                             // Next filter starts rising
                desc <= asc + prod_b;                   // Rising side plus full peak
            end else begin
                asc  <= asc + prod_b;
                desc <= desc + comp_b;
            end
        end
    end

    // desc still holds the finished filter while the peak is in stage two
    assign energy    = desc;
    assign push      = peak_d2;
    assign push_last = peak_d2 & first_d2;             // Bin 0 peak closes the last filter

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module mel_filterbank_tb -o mel_filterbank_sim

output=$(./obj_dir/mel_filterbank_sim 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "^Done: no errors$"; then
    exit 0
fi
echo "Simulation failed"
exit 1

// ==== sim/mel_filterbank_assert.sv ====
`include "melbank_cfg.svh"

module mel_filterbank_assert (
    input logic              clk,
    input logic              reset,
    input logic              push,
    input logic              frame_done,
    input melbank_pkg::log_t bands [`MEL_NUM_BANKS]
);

    localparam int LOG_W = $bits(melbank_pkg::log_t);
    localparam int GAP   = `MEL_NUM_BINS - 1;          // Low cycles between pulses

    logic [`MEL_NUM_BANKS*LOG_W-1:0] bands_flat;
    int unsigned                     gap_count;
    logic                            seen_pulse;

    for (genvar i = 0; i < `MEL_NUM_BANKS; i++) begin : g_flat
        assign bands_flat[i*LOG_W +: LOG_W] = bands[i];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            gap_count  <= 0;
            seen_pulse <= 1'b0;
        end else if (frame_done) begin
            gap_count  <= 0;
            seen_pulse <= 1'b1;
        end else begin
            gap_count <= gap_count + 1;
        end
    end

    no_double_pulse: assert property (@(posedge clk) disable iff (reset)
        frame_done |=> !frame_done)
        else $error("frame_done high on two consecutive cycles");

    pulse_spacing: assert property (@(posedge clk) disable iff (reset)
        seen_pulse |-> (frame_done == (gap_count == GAP)))
        else $error("frame_done pulses not one frame apart");

    bands_hold: assert property (@(posedge clk) disable iff (reset)
        !push |=> $stable(bands_flat))
        else $error("bands changed without a push");

endmodule

bind mel_filterbank mel_filterbank_assert u_assert (
    .clk        (clk),
    .reset      (reset),
    .push       (push),
    .frame_done (frame_done),
    .bands      (bands)
);

// ==== sim/mel_filterbank_tb.sv ====
`include "melbank_cfg.svh"

module mel_filterbank_tb;

    localparam int NUM_BINS        = `MEL_NUM_BINS;
    localparam int NUM_BANKS       = `MEL_NUM_BANKS;
    localparam int SPACING         = `MEL_SPACING;
    localparam int FIRST_PULSE_BIN = 3;                // Bin 0 to frame_done latency
    localparam int TIMEOUT_CYCLES  = 2000;             // Reset plus eight frames and some slack

    localparam int MODE_ZERO   = 0;
    localparam int MODE_CONST  = 1;
    localparam int MODE_SINGLE = 2;
    localparam int MODE_RANDOM = 3;
    localparam int MODE_FULL   = 4;

    localparam int                 SINGLE_POS = 100;   // Offset 4, between peaks 96 and 102
    localparam melbank_pkg::spec_t SINGLE_VAL = 24'h3A5C7F;
    localparam melbank_pkg::spec_t CONST_VAL  = 24'h01D4C3;
    localparam melbank_pkg::spec_t FULL_VAL   = 24'hFFFFFF;

    logic               clk;
    logic               reset;
    melbank_pkg::spec_t spec_in;
    melbank_pkg::log_t  bands [NUM_BANKS];
    logic               frame_done;

    melbank_pkg::spec_t samples [$];                   // Every bin sampled since reset
    int                 bin_count;
    int                 pulse_count;
    int                 cycle_count;
    int                 mode;
    logic               pulse_seen;

    mel_filterbank DUT (
        .clk        (clk),
        .reset      (reset),
        .spec_in    (spec_in),
        .bands      (bands),
        .frame_done (frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the test stream did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Done: errors found");
        $fatal(1);
    end

    task automatic check_value(input string name, input longint unsigned actual,
                               input longint unsigned expected);
        if (actual !== expected) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    // Bin weighted by k/SPACING in Q1.15, truncated
    function automatic longint unsigned scaled(input longint unsigned s, input int k);
        return (s * ((k * 32768) / SPACING)) >> 15;
    endfunction

    function automatic longint unsigned sample_at(input int idx);
        if (idx < 0) begin
            return 0;                                  // Pipeline held zeros before bin 0
        end
        return samples[idx];
    endfunction

    function automatic melbank_pkg::log_t log_code(input longint unsigned e);
        int         m;
        logic [4:0] idx;
        if (e == 0) begin
            return '0;
        end
        m = 0;
        for (int i = 0; i < 64; i++) begin
            if (e[i]) begin
                m = i;
            end
        end
        if (m >= 5) begin
            idx = 5'(e >> (m - 5));
        end else begin
            idx = 5'(e << (5 - m));                    // Mantissa zero-filled below the lead
        end
        return {8'(m), melbank_pkg::log_frac(idx)};
    endfunction

    // Filter j as held in the bank at pulse n, peaks counted from global bin 0
    function automatic longint unsigned filter_energy(input int n, input int j);
        int              peak;
        longint unsigned e;
        peak = (n - 1) * NUM_BINS + j * SPACING;
        e = sample_at(peak);
        for (int k = 1; k < SPACING; k++) begin
            e += scaled(sample_at(peak - SPACING + k), k);
            e += sample_at(peak + k) - scaled(sample_at(peak + k), k);
        end
        return e;
    endfunction

    task automatic compare_model(input int n);
        for (int j = 0; j < NUM_BANKS; j++) begin
            check_value($sformatf("bands[%0d]", j), bands[j], log_code(filter_energy(n, j)));
        end
    endtask

    task automatic expect_uniform(input melbank_pkg::log_t code);
        for (int j = 0; j < NUM_BANKS; j++) begin
            check_value($sformatf("bands[%0d]", j), bands[j], code);
        end
    endtask

    function automatic melbank_pkg::spec_t pattern_value(input int pos);
        case (mode)
            MODE_CONST:  return CONST_VAL;
            MODE_SINGLE: return (pos == SINGLE_POS) ? SINGLE_VAL : '0;
            MODE_RANDOM: return melbank_pkg::spec_t'($urandom);
            MODE_FULL:   return FULL_VAL;
            default:     return '0;
        endcase
    endfunction

    // One bin per cycle, with the frame_done position checked on every bin
    task automatic drive_bin(input melbank_pkg::spec_t value);
        int expected_pulse;
        spec_in = value;
        samples.push_back(value);
        @(posedge clk);
        #1;
        expected_pulse = pulse_count * NUM_BINS + FIRST_PULSE_BIN;
        check_value("frame_done", frame_done, (bin_count == expected_pulse));
        if (frame_done) begin
            pulse_count++;
            pulse_seen = 1'b1;
        end
        bin_count++;
    endtask

    task automatic await_frame_done();
        pulse_seen = 1'b0;
        while (!pulse_seen) begin
            drive_bin(pattern_value(bin_count % NUM_BINS));
        end
        compare_model(pulse_count - 1);
    endtask

    task automatic run_frame();
        while (bin_count % NUM_BINS != 0) begin
            drive_bin(pattern_value(bin_count % NUM_BINS));
        end
        await_frame_done();
    endtask

    task automatic test_reset();
        repeat (5) begin
            @(posedge clk);
            #1;
            expect_uniform('0);
        end
        reset = 1'b0;
        pulse_seen = 1'b0;
        while (!pulse_seen) begin
            drive_bin('0);
            expect_uniform('0);                        // First pulse carries only partial data
        end
    endtask

    task automatic test_zero_frame();
        mode = MODE_ZERO;
        run_frame();
        expect_uniform('0);
    endtask

    task automatic test_single_bin();
        int              filt;
        longint unsigned rise_part;
        mode = MODE_SINGLE;
        run_frame();
        filt = SINGLE_POS / SPACING;
        rise_part = scaled(SINGLE_VAL, SINGLE_POS % SPACING);
        for (int j = 0; j < NUM_BANKS; j++) begin
            if (j == filt) begin
                check_value("bands[low]", bands[j], log_code(SINGLE_VAL - rise_part));
            end else if (j == filt + 1) begin
                check_value("bands[high]", bands[j], log_code(rise_part));
            end else begin
                check_value($sformatf("bands[%0d]", j), bands[j], 0);
            end
        end
    endtask

    // Rising and falling weights at equal offsets sum to one, so each filter sees SPACING bins
    task automatic test_constant();
        mode = MODE_CONST;
        run_frame();
        run_frame();
        expect_uniform(log_code(SPACING * CONST_VAL));
    endtask

    task automatic test_random();
        mode = MODE_RANDOM;
        run_frame();
        run_frame();                                   // Filter 0 rises from the first frame
    endtask

    task automatic test_full_scale();
        mode = MODE_FULL;
        run_frame();
        run_frame();
        expect_uniform(log_code(SPACING * FULL_VAL));
        check_value("bands[0] integer part", bands[0][15:8], 26);
    endtask

    initial begin
        void'($urandom(32'h4863));
        reset = 1'b1;
        spec_in = '0;
        mode = MODE_ZERO;
        bin_count = 0;
        pulse_count = 0;
        pulse_seen = 1'b0;
        test_reset();
        test_zero_frame();
        test_single_bin();
        test_constant();
        test_random();
        test_full_scale();
        $display("Done: no errors");
        $finish;
    end

endmodule
